//--- tag_store_pkg.sv
`default_nettype none

package tag_store_pkg;

  // Cache geometry
  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned NUM_SETS = 64;

  // Set index width, log2 of NUM_SETS
  localparam int unsigned INDEX_W = 6;
  // Width of a stored tag
  localparam int unsigned TAG_W = 10;
  // Binary way number width, log2 of NUM_WAYS
  localparam int unsigned WAY_IDX_W = 2;

  // Set address into the tag memories
  typedef logic [INDEX_W-1:0] index_t;
  // Stored or requested tag
  typedef logic [TAG_W-1:0] tag_t;
  // One bit per way: hit vectors, lock masks, one-hot way choices
  typedef logic [NUM_WAYS-1:0] way_vec_t;
  // Binary way number
  typedef logic [WAY_IDX_W-1:0] way_idx_t;

  // Request kinds accepted by the tag store
  typedef enum logic {
    MODE_LOOKUP = 1'b0,
    MODE_FLUSH  = 1'b1
  } tag_mode_e;

  // Controller FSM
  // ST_RESPOND covers read result, response and write-back
  typedef enum logic {
    ST_IDLE    = 1'b0,
    ST_RESPOND = 1'b1
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- tag_ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tag_ram_if;
  import tag_store_pkg::*;

  // Read request, shared by all ways
  logic                     rd_en;
  index_t                   rd_index;
  tag_t                     cmp_tag;

  // Write request, one enable bit per way
  way_vec_t                 wr_way;
  index_t                   wr_index;
  logic                     wr_valid;
  logic                     wr_dirty;
  tag_t                     wr_tag;

  // Read results, valid the cycle after rd_en until the next rd_en
  way_vec_t                 hit;
  way_vec_t                 ent_valid;
  way_vec_t                 ent_dirty;
  tag_t [NUM_WAYS-1:0]      ent_tag;

  modport ctrl (
    output rd_en, rd_index, cmp_tag,
    output wr_way, wr_index, wr_valid, wr_dirty, wr_tag,
    input  hit, ent_valid, ent_dirty, ent_tag
  );

  modport array (
    input  rd_en, rd_index, cmp_tag,
    input  wr_way, wr_index, wr_valid, wr_dirty, wr_tag,
    output hit, ent_valid, ent_dirty, ent_tag
  );

endinterface

`default_nettype wire

//--- tag_res_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tag_res_if;
  import tag_store_pkg::*;

  // Handshake, transfer on valid and ready at a rising edge
  logic     valid;
  logic     ready;

  // Response payload
  // One-hot way, zero when a miss found no unlocked way
  way_vec_t way;
  logic     hit;
  // Victim or flushed entry was valid and dirty
  logic     evict;
  tag_t     evict_tag;

  modport src (
    output valid, way, hit, evict, evict_tag,
    input  ready
  );

  modport dst (
    input  valid, way, hit, evict, evict_tag,
    output ready
  );

endinterface

`default_nettype wire

//--- tag_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tag_req_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  input  tag_store_pkg::tag_mode_e mode_i,
  input  tag_store_pkg::index_t    index_i,
  input  tag_store_pkg::tag_t      tag_i,
  input  logic                     dirty_i,
  input  tag_store_pkg::way_vec_t  flush_way_i,
  input  tag_store_pkg::way_vec_t  spm_lock_i,
  input  tag_store_pkg::way_vec_t  victim_way_i,
  input  logic                     victim_found_i,
  output logic                     victim_commit_o,
  tag_ram_if.ctrl                  ram,
  tag_res_if.src                   res
);
  import tag_store_pkg::*;

  ctrl_state_e state_q;

  // Request held while responding
  tag_mode_e   mode_q;
  index_t      index_q;
  tag_t        tag_q;
  logic        dirty_q;
  way_vec_t    flush_way_q;

  logic        accept;
  logic        handoff;
  logic        lookup_hit;
  logic        free_way;
  way_idx_t    hit_idx;
  way_idx_t    victim_idx;
  way_idx_t    flush_idx;

  // OR of the indices of all set bits, exact for one-hot input
  function automatic way_idx_t onehot_to_idx(input way_vec_t onehot);
    way_idx_t idx;
    idx = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (onehot[i]) begin
        idx = idx | way_idx_t'(i);
      end
    end
    return idx;
  endfunction

  assign ready_o = (state_q == ST_IDLE);
  assign accept  = valid_i & ready_o;
  assign handoff = res.valid & res.ready;

  // Read of all ways issued on the accepting edge
  assign ram.rd_en    = accept;
  assign ram.rd_index = index_i;
  assign ram.cmp_tag  = tag_i;

  assign lookup_hit = (mode_q == MODE_LOOKUP) & (|ram.hit);
  // Some unlocked way still holds an invalid entry
  assign free_way   = |(~spm_lock_i & ~ram.ent_valid);

  assign hit_idx    = onehot_to_idx(ram.hit);
  assign victim_idx = onehot_to_idx(victim_way_i);
  assign flush_idx  = onehot_to_idx(flush_way_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_RESPOND;
          end
        end
        ST_RESPOND: begin
          // Back to idle on the edge that hands off the response
          if (handoff) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mode_q      <= mode_i;
      index_q     <= index_i;
      tag_q       <= tag_i;
      dirty_q     <= dirty_i;
      flush_way_q <= flush_way_i;
    end
  end

  // Response, built from the registered read results
  // Evict tag reads as zero for an invalid entry
  always_comb begin
    res.valid     = (state_q == ST_RESPOND);
    res.way       = '0;
    res.hit       = 1'b0;
    res.evict     = 1'b0;
    res.evict_tag = '0;
    if (mode_q == MODE_FLUSH) begin
      res.way   = flush_way_q;
      res.evict = ram.ent_valid[flush_idx] & ram.ent_dirty[flush_idx];
      if (ram.ent_valid[flush_idx]) begin
        res.evict_tag = ram.ent_tag[flush_idx];
      end
    end else if (lookup_hit) begin
      res.way = ram.hit;
      res.hit = 1'b1;
    end else if (victim_found_i) begin
      res.way   = victim_way_i;
      res.evict = ram.ent_valid[victim_idx] & ram.ent_dirty[victim_idx];
      if (ram.ent_valid[victim_idx]) begin
        res.evict_tag = ram.ent_tag[victim_idx];
      end
    end
  end

  // Write-back on handoff
  always_comb begin
    ram.wr_way      = '0;
    ram.wr_index    = index_q;
    ram.wr_valid    = 1'b0;
    ram.wr_dirty    = 1'b0;
    ram.wr_tag      = '0;
    victim_commit_o = 1'b0;
    if (handoff) begin
      if (mode_q == MODE_FLUSH) begin
        // Clear the named way
        ram.wr_way = flush_way_q;
      end else if (lookup_hit) begin
        // Only a clean entry hit by a dirty request changes
        if (dirty_q && !ram.ent_dirty[hit_idx]) begin
          ram.wr_way   = ram.hit;
          ram.wr_valid = 1'b1;
          ram.wr_dirty = 1'b1;
          ram.wr_tag   = tag_q;
        end
      end else if (victim_found_i) begin
        ram.wr_way      = victim_way_i;
        ram.wr_valid    = 1'b1;
        ram.wr_dirty    = dirty_q;
        ram.wr_tag      = tag_q;
        // Round-robin pointer only advances when no way was free
        victim_commit_o = ~free_way;
      end
    end
  end

  // Pending response stays up and unchanged until the spill buffer takes it
  a_res_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (res.valid && !res.ready) |=> (res.valid && $stable(res.way) && $stable(res.evict)))
    else $error("tag_req_ctrl: response changed before handoff");

endmodule

`default_nettype wire

//--- tag_way_array.sv
`timescale 1ns/1ps
`default_nettype none

module tag_way_array (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  tag_store_pkg::way_vec_t cmp_mask_i,
  tag_ram_if.array                ram
);
  import tag_store_pkg::*;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    // Entry storage for this way
    logic                val_mem [NUM_SETS];
    logic                dirty_mem [NUM_SETS];
    tag_t                tag_mem [NUM_SETS];

    // Registered read port
    logic                val_q;
    logic                dirty_q;
    logic                hit_q;
    tag_t                tag_q;

    // Status bits are cleared by reset, tags are not
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          val_mem[s]   <= 1'b0;
          dirty_mem[s] <= 1'b0;
        end
      end else if (ram.wr_way[w]) begin
        val_mem[ram.wr_index]   <= ram.wr_valid;
        dirty_mem[ram.wr_index] <= ram.wr_dirty;
      end
    end

    always_ff @(posedge clk_i) begin
      if (ram.wr_way[w]) begin
        tag_mem[ram.wr_index] <= ram.wr_tag;
      end
    end

    // Compare happens at the read edge, the result is held with the entry
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        val_q   <= 1'b0;
        dirty_q <= 1'b0;
        hit_q   <= 1'b0;
      end else if (ram.rd_en) begin
        val_q   <= val_mem[ram.rd_index];
        dirty_q <= dirty_mem[ram.rd_index];
        hit_q   <= cmp_mask_i[w] & val_mem[ram.rd_index]
                   & (tag_mem[ram.rd_index] == ram.cmp_tag);
      end
    end

    always_ff @(posedge clk_i) begin
      if (ram.rd_en) begin
        tag_q <= tag_mem[ram.rd_index];
      end
    end

    assign ram.ent_valid[w] = val_q;
    assign ram.ent_dirty[w] = dirty_q;
    assign ram.hit[w]       = hit_q;
    assign ram.ent_tag[w]   = tag_q;
  end

  // A tag lives in at most one way of a set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(ram.hit))
    else $error("tag_way_array: tag hit in more than one way");

endmodule

`default_nettype wire

//--- victim_select.sv
`timescale 1ns/1ps
`default_nettype none

module victim_select (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  tag_store_pkg::way_vec_t ent_valid_i,
  input  tag_store_pkg::way_vec_t spm_lock_i,
  input  logic                    commit_i,
  output tag_store_pkg::way_vec_t victim_way_o,
  output logic                    found_o,
  output logic                    used_ptr_o
);
  import tag_store_pkg::*;

  way_idx_t ptr_q;
  way_idx_t chosen;
  way_vec_t avail;
  way_vec_t free_vec;

  assign avail    = ~spm_lock_i;
  assign free_vec = avail & ~ent_valid_i;
  assign found_o  = |avail;

  always_comb begin
    way_idx_t cand;
    chosen     = '0;
    used_ptr_o = 1'b0;
    cand       = '0;
    if (|free_vec) begin
      // Lowest free way wins, so scan downwards
      for (int i = NUM_WAYS - 1; i >= 0; i--) begin
        if (free_vec[i]) begin
          chosen = way_idx_t'(i);
        end
      end
    end else if (|avail) begin
      used_ptr_o = 1'b1;
      // Nearest unlocked way at or after the pointer, wrapping
      for (int k = NUM_WAYS - 1; k >= 0; k--) begin
        cand = ptr_q + way_idx_t'(k);
        if (avail[cand]) begin
          chosen = cand;
        end
      end
    end
  end

  assign victim_way_o = found_o ? (way_vec_t'(1) << chosen) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (commit_i) begin
      ptr_q <= chosen + way_idx_t'(1);
    end
  end

  a_victim_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(victim_way_o))
    else $error("victim_select: more than one victim way");

endmodule

`default_nettype wire

//--- tag_res_spill.sv
`timescale 1ns/1ps
`default_nettype none

module tag_res_spill (
  input  logic                    clk_i,
  input  logic                    rst_i,
  tag_res_if.dst                  res,
  output logic                    valid_o,
  input  logic                    ready_i,
  output tag_store_pkg::way_vec_t res_way_o,
  output logic                    res_hit_o,
  output logic                    res_evict_o,
  output tag_store_pkg::tag_t     res_evict_tag_o
);
  import tag_store_pkg::*;

  // Two slots used as a small ring
  way_vec_t   way_q [2];
  logic [1:0] hit_q;
  logic [1:0] evict_q;
  tag_t       tag_q [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign res.ready = (count_q != 2'd2);
  assign valid_o   = (count_q != 2'd0);
  assign push      = res.valid & res.ready;
  assign pop       = valid_o & ready_i;

  // Oldest entry on the outputs
  assign res_way_o       = way_q[rd_ptr_q];
  assign res_hit_o       = hit_q[rd_ptr_q];
  assign res_evict_o     = evict_q[rd_ptr_q];
  assign res_evict_tag_o = tag_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      way_q[wr_ptr_q]   <= res.way;
      hit_q[wr_ptr_q]   <= res.hit;
      evict_q[wr_ptr_q] <= res.evict;
      tag_q[wr_ptr_q]   <= res.evict_tag;
    end
  end

  // Stalled output holds its entry
  a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(res_way_o) && $stable(res_evict_tag_o)))
    else $error("tag_res_spill: output changed while stalled");

endmodule

`default_nettype wire

//--- tag_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Request side
  input  logic                     valid_i,
  output logic                     ready_o,
  input  tag_store_pkg::tag_mode_e mode_i,
  input  tag_store_pkg::index_t    index_i,
  input  tag_store_pkg::tag_t      tag_i,
  input  logic                     dirty_i,
  input  tag_store_pkg::way_vec_t  flush_way_i,
  input  tag_store_pkg::way_vec_t  spm_lock_i,
  // Response side
  output logic                     valid_o,
  input  logic                     ready_i,
  output tag_store_pkg::way_vec_t  res_way_o,
  output logic                     res_hit_o,
  output logic                     res_evict_o,
  output tag_store_pkg::tag_t      res_evict_tag_o
);
  import tag_store_pkg::*;

  tag_ram_if ram_if ();
  tag_res_if res_if ();

  way_vec_t victim_way;
  logic     victim_found;
  logic     victim_commit;
  way_vec_t cmp_mask;

  // Compare mask is sampled at the read edge only
  assign cmp_mask = (mode_i == MODE_FLUSH) ? flush_way_i : ~spm_lock_i;

  tag_req_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .valid_i         (valid_i),
    .ready_o         (ready_o),
    .mode_i          (mode_i),
    .index_i         (index_i),
    .tag_i           (tag_i),
    .dirty_i         (dirty_i),
    .flush_way_i     (flush_way_i),
    .spm_lock_i      (spm_lock_i),
    .victim_way_i    (victim_way),
    .victim_found_i  (victim_found),
    .victim_commit_o (victim_commit),
    .ram             (ram_if.ctrl),
    .res             (res_if.src)
  );

  tag_way_array u_array (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cmp_mask_i (cmp_mask),
    .ram        (ram_if.array)
  );

  // Controller derives pointer use from the free-way check itself
  victim_select u_victim (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ent_valid_i  (ram_if.ent_valid),
    .spm_lock_i   (spm_lock_i),
    .commit_i     (victim_commit),
    .victim_way_o (victim_way),
    .found_o      (victim_found),
    .used_ptr_o   ()
  );

  tag_res_spill u_spill (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .res             (res_if.dst),
    .valid_o         (valid_o),
    .ready_i         (ready_i),
    .res_way_o       (res_way_o),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

endmodule

`default_nettype wire

//--- tb_tag_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tag_checker (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     valid_i,
  input  logic                     ready_o,
  input  tag_store_pkg::tag_mode_e mode_i,
  input  tag_store_pkg::index_t    index_i,
  input  tag_store_pkg::tag_t      tag_i,
  input  logic                     dirty_i,
  input  tag_store_pkg::way_vec_t  flush_way_i,
  input  tag_store_pkg::way_vec_t  spm_lock_i,
  input  logic                     valid_o,
  input  logic                     ready_i,
  input  tag_store_pkg::way_vec_t  res_way_o,
  input  logic                     res_hit_o,
  input  logic                     res_evict_o,
  input  tag_store_pkg::tag_t      res_evict_tag_o,
  output int                       value_errs_o,
  output int                       proto_errs_o,
  output int                       pending_o
);
  import tag_store_pkg::*;

  // Reference copy of every entry
  logic        m_valid [NUM_SETS][NUM_WAYS];
  logic        m_dirty [NUM_SETS][NUM_WAYS];
  tag_t        m_tag [NUM_SETS][NUM_WAYS];
  int          m_ptr;

  // Expected responses, oldest first, packed as way, hit, evict, evict tag
  logic [15:0] exp_q [$];
  logic [15:0] exp_res;
  // 1 means valid_o must still be low, 2 means it must be high
  int          lat_stage;
  logic        check_reset_state = 1'b0;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          pending = 0;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;
  assign pending_o    = pending;

  function automatic logic [15:0] pack_res(way_vec_t way, logic hit, logic evict, tag_t t);
    return {way, hit, evict, t};
  endfunction

  // Apply one request to the model and return its expected response
  function automatic logic [15:0] model_request(tag_mode_e m, index_t s, tag_t t, logic d,
                                                way_vec_t fw, way_vec_t lock);
    int          w;
    int          hit_way;
    int          victim;
    logic [15:0] res;
    w       = 0;
    hit_way = -1;
    victim  = -1;
    res     = pack_res('0, 1'b0, 1'b0, '0);
    if (m == MODE_FLUSH) begin
      for (int i = 0; i < NUM_WAYS; i++) begin
        if (fw[i]) begin
          w = i;
        end
      end
      res = pack_res(fw, 1'b0, m_valid[s][w] & m_dirty[s][w],
                     m_valid[s][w] ? m_tag[s][w] : '0);
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
      m_tag[s][w]   = '0;
      return res;
    end
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (!lock[i] && m_valid[s][i] && m_tag[s][i] == t) begin
        hit_way = i;
      end
    end
    if (hit_way >= 0) begin
      // A dirty request marks a clean entry dirty
      if (d) begin
        m_dirty[s][hit_way] = 1'b1;
      end
      return pack_res(way_vec_t'(1) << hit_way, 1'b1, 1'b0, '0);
    end
    // Miss takes the lowest unlocked invalid way
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!lock[i] && !m_valid[s][i]) begin
        victim = i;
      end
    end
    // Full set, first unlocked way from the pointer on
    if (victim < 0) begin
      for (int k = NUM_WAYS - 1; k >= 0; k--) begin
        if (!lock[(m_ptr + k) % NUM_WAYS]) begin
          victim = (m_ptr + k) % NUM_WAYS;
        end
      end
      if (victim >= 0) begin
        m_ptr = (victim + 1) % NUM_WAYS;
      end
    end
    // All ways locked, zero way and no write
    if (victim < 0) begin
      return res;
    end
    res = pack_res(way_vec_t'(1) << victim, 1'b0, m_valid[s][victim] & m_dirty[s][victim],
                   m_valid[s][victim] ? m_tag[s][victim] : '0);
    m_valid[s][victim] = 1'b1;
    m_dirty[s][victim] = d;
    m_tag[s][victim]   = t;
    return res;
  endfunction

  always @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          m_valid[s][w] = 1'b0;
          m_dirty[s][w] = 1'b0;
          m_tag[s][w]   = '0;
        end
      end
      m_ptr = 0;
      exp_q.delete();
      lat_stage = 0;
      check_reset_state = 1'b1;
    end else begin
      // State right after reset
      if (check_reset_state) begin
        if (!ready_o || valid_o) begin
          proto_errs++;
          $display("ERROR at %0t: ready_o not high or valid_o not low after reset", $time);
        end
        check_reset_state = 1'b0;
      end
      // Two in the buffer and one in the controller leaves no room
      if (ready_o && exp_q.size() >= 3) begin
        proto_errs++;
        $display("ERROR at %0t: ready_o high with three responses pending", $time);
      end
      if (lat_stage == 1) begin
        if (valid_o) begin
          proto_errs++;
          $display("ERROR at %0t: valid_o rose one cycle after the request", $time);
        end
        lat_stage = 2;
      end else if (lat_stage == 2) begin
        if (!valid_o) begin
          proto_errs++;
          $display("ERROR at %0t: valid_o not high two cycles after the request", $time);
        end
        lat_stage = 0;
      end
      // Response taken
      if (valid_o && ready_i) begin
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("ERROR at %0t: response taken with no request outstanding", $time);
        end else begin
          exp_res = exp_q.pop_front();
          if ({res_way_o, res_hit_o, res_evict_o, res_evict_tag_o} !== exp_res) begin
            value_errs++;
            $display("FAIL %0t: got way %b hit %b evict %b tag %h, expected way %b hit %b evict %b tag %h",
                     $time, res_way_o, res_hit_o, res_evict_o, res_evict_tag_o,
                     exp_res[15:12], exp_res[11], exp_res[10], exp_res[9:0]);
          end
        end
      end
      // Request accepted, an empty buffer gives the fixed latency
      if (valid_i && ready_o) begin
        exp_q.push_back(model_request(mode_i, index_i, tag_i, dirty_i, flush_way_i, spm_lock_i));
        if (!valid_o) begin
          lat_stage = 1;
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- tb_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tag_store;
  import tag_store_pkg::*;

  localparam int          NUM_REQS    = 2000;
  localparam int          WAIT_LIMIT  = 200;
  localparam int          DRAIN_LIMIT = 1000;
  localparam logic [31:0] LCG_SEED    = 32'd71534;
  // Few sets and tags so sets fill up and tags repeat
  localparam int          USED_SETS   = 8;
  localparam int          USED_TAGS   = 12;

  logic        clk_i;
  logic        rst_i;
  logic        valid_i;
  logic        ready_o;
  tag_mode_e   mode_i;
  index_t      index_i;
  tag_t        tag_i;
  logic        dirty_i;
  way_vec_t    flush_way_i;
  way_vec_t    spm_lock_i;
  logic        valid_o;
  logic        ready_i;
  way_vec_t    res_way_o;
  logic        res_hit_o;
  logic        res_evict_o;
  tag_t        res_evict_tag_o;

  // Separate streams for requests and back-pressure
  logic [31:0] req_state;
  logic [31:0] rdy_state = LCG_SEED ^ 32'h2f6b_91c3;
  // 0 random, 1 held high, 2 held low
  int          ready_mode;
  int          timeouts;
  int          stall_errs;
  logic        aborted;
  int          value_errs;
  int          proto_errs;
  int          pending;
  int          cnt;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int draw(input int range);
    req_state = lcg_step(req_state);
    return int'(req_state[30:16]) % range;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  tag_store_top dut_i (
    .clk_i, .rst_i, .valid_i, .ready_o, .mode_i, .index_i, .tag_i, .dirty_i,
    .flush_way_i, .spm_lock_i, .valid_o, .ready_i, .res_way_o, .res_hit_o,
    .res_evict_o, .res_evict_tag_o
  );

  tb_tag_checker chk_i (
    .clk_i, .rst_i, .valid_i, .ready_o, .mode_i, .index_i, .tag_i, .dirty_i,
    .flush_way_i, .spm_lock_i, .valid_o, .ready_i, .res_way_o, .res_hit_o,
    .res_evict_o, .res_evict_tag_o,
    .value_errs_o (value_errs),
    .proto_errs_o (proto_errs),
    .pending_o    (pending)
  );

  // Back-pressure, mode sampled at the edge and applied 1 ns later
  initial begin
    int mode_now;
    ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      mode_now = ready_mode;
      #1;
      if (mode_now == 1) begin
        ready_i = 1'b1;
      end else if (mode_now == 2) begin
        ready_i = 1'b0;
      end else begin
        rdy_state = lcg_step(rdy_state);
        ready_i = (rdy_state[29:16] % 3) != 0;
      end
    end
  end

  // Hold a request until an edge with ready_o, leaves at edge plus 1 ns
  task automatic issue_req(input tag_mode_e m, input index_t idx, input tag_t t,
                           input logic d, input way_vec_t fw);
    int n;
    n = 0;
    mode_i      = m;
    index_i     = idx;
    tag_i       = t;
    dirty_i     = d;
    flush_way_i = fw;
    valid_i     = 1'b1;
    @(posedge clk_i);
    while (!ready_o && n < WAIT_LIMIT) begin
      n++;
      @(posedge clk_i);
    end
    if (!ready_o) begin
      $display("ERROR at %0t: timeout, ready_o stayed low for %0d cycles", $time, n);
      timeouts++;
      aborted = 1'b1;
    end
    #1;
    valid_i = 1'b0;
  endtask

  // Controller back in idle, nothing in flight inside it
  task automatic wait_idle;
    int n;
    n = 0;
    @(posedge clk_i);
    while (!ready_o && n < WAIT_LIMIT) begin
      n++;
      @(posedge clk_i);
    end
    if (!ready_o) begin
      $display("ERROR at %0t: timeout, controller did not return to idle", $time);
      timeouts++;
      aborted = 1'b1;
    end
    #1;
  endtask

  task automatic idle_cycles(input int n);
    if (n > 0) begin
      repeat (n) @(posedge clk_i);
      #1;
    end
  endtask

  task automatic random_req;
    int     kind;
    int     sel_way;
    index_t idx;
    tag_t   t;
    logic   d;
    kind    = draw(8);
    idx     = index_t'(draw(USED_SETS));
    t       = tag_t'(draw(USED_TAGS));
    d       = (draw(2) == 1);
    sel_way = draw(NUM_WAYS);
    if (kind == 0) begin
      issue_req(MODE_FLUSH, idx, t, d, way_vec_t'(1) << sel_way);
    end else begin
      issue_req(MODE_LOOKUP, idx, t, d, way_vec_t'(1) << sel_way);
    end
  endtask

  // New lock mask, never all ways locked
  task automatic change_lock;
    way_vec_t new_lock;
    way_vec_t opened;
    new_lock = way_vec_t'(draw(16));
    if (&new_lock) begin
      new_lock[draw(NUM_WAYS)] = 1'b0;
    end
    opened = spm_lock_i & ~new_lock;
    // Empty reopened ways so a tag never sits in two ways of a set
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int s = 0; s < USED_SETS; s++) begin
        if (opened[w] && !aborted) begin
          issue_req(MODE_FLUSH, index_t'(s), '0, 1'b0, way_vec_t'(1) << w);
        end
      end
    end
    wait_idle();
    spm_lock_i = new_lock;
  endtask

  initial begin
    req_state   = LCG_SEED;
    valid_i     = 1'b0;
    mode_i      = MODE_LOOKUP;
    index_i     = '0;
    tag_i       = '0;
    dirty_i     = 1'b0;
    flush_way_i = '0;
    spm_lock_i  = '0;
    ready_mode  = 1;
    timeouts    = 0;
    stall_errs  = 0;
    aborted     = 1'b0;
    rst_i       = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Miss into way 0, dirty hit, flush with eviction, then miss again
    issue_req(MODE_LOOKUP, 6'd0, 10'h003, 1'b0, 4'b0001);
    idle_cycles(2);
    issue_req(MODE_LOOKUP, 6'd0, 10'h003, 1'b1, 4'b0001);
    idle_cycles(2);
    issue_req(MODE_FLUSH, 6'd0, 10'h000, 1'b0, 4'b0001);
    idle_cycles(2);
    issue_req(MODE_LOOKUP, 6'd0, 10'h003, 1'b0, 4'b0001);
    idle_cycles(2);
    // Sink always ready, buffer empty at each request
    for (int i = 0; i < 40 && !aborted; i++) begin
      random_req();
      idle_cycles(2);
    end

    // Stalled sink, two responses buffered and one held in the controller
    wait_idle();
    idle_cycles(2);
    ready_mode = 2;
    idle_cycles(2);
    for (int i = 0; i < 3 && !aborted; i++) begin
      random_req();
    end
    repeat (8) begin
      @(posedge clk_i);
      if (ready_o) begin
        stall_errs++;
        $display("ERROR at %0t: ready_o high while the response buffer was full", $time);
      end
    end
    #1;
    ready_mode = 0;

    // Random traffic with random back-pressure and lock changes
    for (int i = 0; i < NUM_REQS && !aborted; i++) begin
      if (draw(64) == 0) begin
        change_lock();
      end
      random_req();
      idle_cycles(draw(3));
    end

    // Drain all outstanding responses
    ready_mode = 1;
    cnt = 0;
    @(posedge clk_i);
    #1;
    while ((pending != 0 || valid_o) && cnt < DRAIN_LIMIT) begin
      cnt++;
      @(posedge clk_i);
      #1;
    end
    if (pending != 0 || valid_o) begin
      $display("ERROR at %0t: timeout, %0d responses never came out", $time, pending);
      timeouts++;
    end

    $display("errors: %0d value, %0d protocol, %0d timeout, %0d responses missing",
             value_errs, proto_errs + stall_errs, timeouts, pending);
    if (value_errs == 0 && proto_errs == 0 && stall_errs == 0 && timeouts == 0
        && pending == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
tag_store_pkg.sv
tag_ram_if.sv
tag_res_if.sv
tag_req_ctrl.sv
tag_way_array.sv
victim_select.sv
tag_res_spill.sv
tag_store_top.sv
tb_tag_checker.sv
tb_tag_store.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the tag store testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_tag_store \
  -f sources.f \
  -o sim_tag_store

./obj_dir/sim_tag_store 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
